// File: hw/fetch_pkg.sv
package fetch_pkg;

  // ####################################################################
  // Widths and word types
  // ####################################################################

  localparam int xlen = 32;                    // Data and address width.

  typedef logic [xlen-1:0] addr_t;             // Fetch address, one word.
  typedef logic [xlen-1:0] inst_t;             // One instruction word.

  // ####################################################################
  // Configuration register map
  // ####################################################################

  typedef logic [1:0] reg_addr_t;              // Register block offset.

  // Bit 0 holds the fetch enable.
  localparam reg_addr_t REG_CTRL     = 2'd0;

  // Writing this register starts a flush toward the stored PC.
  localparam reg_addr_t REG_REDIRECT = 2'd1;

  // Flush busy in bit 31, outstanding request count in the low bits.
  localparam reg_addr_t REG_STATUS   = 2'd2;

endpackage

// File: hw/inst_fifo.sv
`timescale 1ns/1ns

module inst_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_clear,
  input  logic             i_push,
  input  fetch_pkg::addr_t i_push_pc,
  input  fetch_pkg::inst_t i_push_inst,
  input  logic             i_pop,
  output logic             o_empty,
  output logic             o_almost_full,
  output fetch_pkg::addr_t o_pc,
  output fetch_pkg::inst_t o_inst
);
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
  localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  fetch_pkg::addr_t       pc_mem   [FIFO_DEPTH];
  fetch_pkg::inst_t       inst_mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  always_comb begin
    do_push = i_push && !i_clear && (count != COUNT_WIDTH'(FIFO_DEPTH));
    do_pop  = i_pop && !i_clear && !o_empty;
  end

  assign o_empty       = (count == '0);
  assign o_almost_full = (count >= COUNT_WIDTH'(FIFO_DEPTH - 1));   // One slot or fewer left.

  // Storage holds payload only.
  always_ff @(posedge i_clk) begin
    if (do_push) begin
      pc_mem[wr_ptr]   <= i_push_pc;
      inst_mem[wr_ptr] <= i_push_inst;
    end
  end

  assign o_pc   = pc_mem[rd_ptr];
  assign o_inst = inst_mem[rd_ptr];

  // ####################################################################
  // Pointers and occupancy
  // ####################################################################

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;                                 // Drop everything in one edge.
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage #(
  parameter int               FIFO_DEPTH = 4,
  parameter fetch_pkg::addr_t INITIAL_PC = 32'h8000_0000
) (
  input  logic                                   i_clk,
  input  logic                                   i_rst_n,
  input  logic                                   i_enable,
  input  logic                                   i_redirect,
  input  fetch_pkg::addr_t                       i_redirect_pc,
  output logic                                   o_flush_busy,
  output logic [$clog2(FIFO_DEPTH + 1)-1:0]      o_outstanding,
  output logic                                   o_bus_req_valid,
  output fetch_pkg::addr_t                       o_bus_addr,
  input  logic                                   i_bus_req_ready,
  input  logic                                   i_bus_rsp_valid,
  input  fetch_pkg::inst_t                       i_bus_rsp_data,
  output logic                                   o_valid,
  output fetch_pkg::addr_t                       o_pc,
  output fetch_pkg::inst_t                       o_inst,
  input  logic                                   i_stall
);
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  fetch_pkg::addr_t       req_pc;
  fetch_pkg::addr_t       rsp_pc;
  fetch_pkg::addr_t       target_pc;
  fetch_pkg::addr_t       restart_pc;
  logic                   req_valid;
  logic                   req_ack;
  logic                   req_hold;
  logic                   req_next;
  logic                   issue;
  logic                   flush;
  logic                   flush_busy;
  logic                   flush_done;
  logic [COUNT_WIDTH-1:0] outstanding;
  logic [COUNT_WIDTH-1:0] outstanding_next;
  logic [COUNT_WIDTH-1:0] used;               // Requests issued and not yet taken.
  logic                   fifo_push;
  logic                   fifo_pop;
  logic                   fifo_empty;

  // ####################################################################
  // Flush control
  // ####################################################################

  // Disable behaves like a redirect to the initial PC.
  always_comb begin
    flush      = i_redirect || flush_busy || !i_enable;
    restart_pc = !i_enable ? INITIAL_PC : (i_redirect ? i_redirect_pc : target_pc);
    flush_done = flush && !req_hold && (outstanding_next == '0);
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      flush_busy <= 1'b0;
      target_pc  <= INITIAL_PC;
    end else begin
      flush_busy <= flush && !flush_done;         // Ends at once when nothing is in flight.
      if (!i_enable) begin
        target_pc <= INITIAL_PC;
      end else if (i_redirect) begin
        target_pc <= i_redirect_pc;
      end
    end
  end

  // ####################################################################
  // Request side
  // ####################################################################

  always_comb begin
    req_ack  = req_valid && i_bus_req_ready;
    req_hold = req_valid && !i_bus_req_ready;     // Address must stay put.
    req_next = i_enable &&
               (flush ? flush_done : (fifo_pop || (used < COUNT_WIDTH'(FIFO_DEPTH))));
    issue    = req_next && !req_hold;
  end

  always_comb begin
    outstanding_next = outstanding;
    if (req_ack && !i_bus_rsp_valid) begin
      outstanding_next = outstanding + 1'b1;
    end else if (!req_ack && i_bus_rsp_valid) begin
      outstanding_next = outstanding - 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      req_valid   <= 1'b0;
      req_pc      <= INITIAL_PC;
      outstanding <= '0;
      used        <= '0;
    end else begin
      outstanding <= outstanding_next;
      if (!req_hold) begin
        req_valid <= req_next;
        if (flush) begin
          req_pc <= restart_pc;
        end else if (req_ack) begin
          req_pc <= req_pc + 32'd4;
        end
      end
      if (flush) begin
        used <= COUNT_WIDTH'(issue);             // FIFO is empty after the flush.
      end else begin
        used <= used + COUNT_WIDTH'(issue) - COUNT_WIDTH'(fifo_pop);
      end
    end
  end

  // ####################################################################
  // Response side
  // ####################################################################

  always_comb begin
    fifo_push = i_bus_rsp_valid && !flush;        // In-flight words are dropped on flush.
    fifo_pop  = o_valid && !i_stall;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_pc <= INITIAL_PC;
    end else if (flush) begin
      rsp_pc <= restart_pc;
    end else if (fifo_push) begin
      rsp_pc <= rsp_pc + 32'd4;
    end
  end

  inst_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_inst_fifo (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_clear       (flush),
    .i_push        (fifo_push),
    .i_push_pc     (rsp_pc),
    .i_push_inst   (i_bus_rsp_data),
    .i_pop         (fifo_pop),
    .o_empty       (fifo_empty),
    .o_almost_full (),
    .o_pc          (o_pc),
    .o_inst        (o_inst)
  );

  assign o_valid         = !fifo_empty && !flush;
  assign o_bus_req_valid = req_valid;
  assign o_bus_addr      = req_pc;
  assign o_flush_busy    = flush_busy;
  assign o_outstanding   = outstanding;

endmodule

// File: hw/fetch_ctrl_regs.sv
`timescale 1ns/1ns

module fetch_ctrl_regs #(
  parameter int               FIFO_DEPTH = 4,
  parameter fetch_pkg::addr_t INITIAL_PC = 32'h8000_0000
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_cfg_we,
  input  fetch_pkg::reg_addr_t              i_cfg_addr,
  input  logic [fetch_pkg::xlen-1:0]        i_cfg_wdata,
  output logic [fetch_pkg::xlen-1:0]        o_cfg_rdata,
  output logic                              o_enable,
  output logic                              o_redirect,
  output fetch_pkg::addr_t                  o_redirect_pc,
  input  logic                              i_flush_busy,
  input  logic [$clog2(FIFO_DEPTH + 1)-1:0] i_outstanding
);
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  logic             enable;
  logic             redirect;
  fetch_pkg::addr_t redirect_pc;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      enable      <= 1'b0;
      redirect    <= 1'b0;
      redirect_pc <= INITIAL_PC;
    end else begin
      redirect <= i_cfg_we && (i_cfg_addr == fetch_pkg::REG_REDIRECT);   // One-cycle pulse.
      if (i_cfg_we && (i_cfg_addr == fetch_pkg::REG_CTRL)) begin
        enable <= i_cfg_wdata[0];
      end
      if (i_cfg_we && (i_cfg_addr == fetch_pkg::REG_REDIRECT)) begin
        redirect_pc <= {i_cfg_wdata[fetch_pkg::xlen-1:2], 2'b00};     // Word aligned.
      end
    end
  end

  // Read-back path.
  always_comb begin
    o_cfg_rdata = '0;
    case (i_cfg_addr)
      fetch_pkg::REG_CTRL:     o_cfg_rdata[0] = enable;
      fetch_pkg::REG_REDIRECT: o_cfg_rdata    = redirect_pc;
      fetch_pkg::REG_STATUS: begin
        o_cfg_rdata[fetch_pkg::xlen-1]  = i_flush_busy;
        o_cfg_rdata[COUNT_WIDTH-1:0]    = i_outstanding;
      end
      default:                 o_cfg_rdata = '0;
    endcase
  end

  assign o_enable      = enable;
  assign o_redirect    = redirect;
  assign o_redirect_pc = redirect_pc;

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
  parameter int               FIFO_DEPTH = 4,
  parameter fetch_pkg::addr_t INITIAL_PC = 32'h8000_0000
) (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_cfg_we,
  input  fetch_pkg::reg_addr_t       i_cfg_addr,
  input  logic [fetch_pkg::xlen-1:0] i_cfg_wdata,
  output logic [fetch_pkg::xlen-1:0] o_cfg_rdata,
  output logic                       o_bus_req_valid,
  output fetch_pkg::addr_t           o_bus_addr,
  input  logic                       i_bus_req_ready,
  input  logic                       i_bus_rsp_valid,
  input  fetch_pkg::inst_t           i_bus_rsp_data,
  output logic                       o_valid,
  output fetch_pkg::addr_t           o_pc,
  output fetch_pkg::inst_t           o_inst,
  input  logic                       i_stall
);
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  logic                   enable;
  logic                   redirect;
  fetch_pkg::addr_t       redirect_pc;
  logic                   flush_busy;
  logic [COUNT_WIDTH-1:0] outstanding;

  // ####################################################################
  // Configuration registers
  // ####################################################################

  fetch_ctrl_regs #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .INITIAL_PC (INITIAL_PC)
  ) u_ctrl_regs (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_cfg_we      (i_cfg_we),
    .i_cfg_addr    (i_cfg_addr),
    .i_cfg_wdata   (i_cfg_wdata),
    .o_cfg_rdata   (o_cfg_rdata),
    .o_enable      (enable),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .i_flush_busy  (flush_busy),
    .i_outstanding (outstanding)
  );

  // ####################################################################
  // Fetch pipeline
  // ####################################################################

  fetch_stage #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .INITIAL_PC (INITIAL_PC)
  ) u_fetch_stage (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_enable        (enable),
    .i_redirect      (redirect),
    .i_redirect_pc   (redirect_pc),
    .o_flush_busy    (flush_busy),
    .o_outstanding   (outstanding),
    .o_bus_req_valid (o_bus_req_valid),
    .o_bus_addr      (o_bus_addr),
    .i_bus_req_ready (i_bus_req_ready),
    .i_bus_rsp_valid (i_bus_rsp_valid),
    .i_bus_rsp_data  (i_bus_rsp_data),
    .o_valid         (o_valid),
    .o_pc            (o_pc),
    .o_inst          (o_inst),
    .i_stall         (i_stall)
  );

endmodule

// File: verif/inst_bus_model.sv
`timescale 1ns/1ns

module inst_bus_model (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_req_valid,
  input  fetch_pkg::addr_t i_req_addr,
  input  logic             i_ready,                   // Acceptance choice for this cycle.
  input  logic [3:0]       i_latency,                 // Delay for a request accepted now.
  output logic             o_req_ready,
  output logic             o_rsp_valid,
  output fetch_pkg::addr_t o_rsp_addr
);
  fetch_pkg::addr_t addr_q[$];                        // Accepted addresses, oldest first.
  int unsigned      due_q[$];                         // Cycle each response may leave.
  int unsigned      cycle;

  assign o_req_ready = i_ready;

  // Responses leave strictly in acceptance order, at most one per cycle.
  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      addr_q.delete();
      due_q.delete();
      cycle = 0;
      o_rsp_valid <= 1'b0;
      o_rsp_addr  <= '0;
    end else begin
      o_rsp_valid <= 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        o_rsp_valid <= 1'b1;
        o_rsp_addr  <= addr_q[0];
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      if (i_req_valid && i_ready) begin
        addr_q.push_back(i_req_addr);
        due_q.push_back(cycle + ((i_latency == 4'd0) ? 32'd1 : 32'(i_latency)));
      end
      cycle = cycle + 1;
    end
  end

endmodule

// File: verif/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;
  localparam int               CLK_PERIOD = 10;
  localparam int               FIFO_DEPTH = 4;
  localparam fetch_pkg::addr_t INITIAL_PC = 32'h8000_0000;
  localparam fetch_pkg::addr_t PC_TRAFFIC = 32'h0000_4000;
  localparam fetch_pkg::addr_t PC_IDLE    = 32'h0001_2340;
  localparam fetch_pkg::addr_t PC_PARKED  = 32'h00ab_cd00;
  localparam int N_SEQ     = 64;
  localparam int N_RAND    = 200;
  localparam int N_PRE     = 20;
  localparam int N_POST    = 24;
  localparam int N_IDLE    = 16;
  localparam int N_RESTART = 32;
  localparam int WATCHDOG_CYCLES = (N_SEQ + N_RAND + N_PRE + N_POST + N_IDLE + N_RESTART) * 40;
  localparam int STALL_NONE   = 0;
  localparam int STALL_RANDOM = 1;
  localparam int STALL_HOLD   = 2;

  logic clk, rst_n, cfg_we, stall, bus_ready, bus_req_valid, bus_rsp_valid, out_valid;
  logic bus_req_ready;
  fetch_pkg::reg_addr_t cfg_addr;
  logic [31:0] cfg_wdata, cfg_rdata, rng, d;
  logic [3:0]  bus_lat;
  fetch_pkg::addr_t bus_addr, bus_rsp_addr, out_pc, exp_pc, held_pc, req_held_addr;
  fetch_pkg::inst_t bus_rsp_data, out_inst, held_inst;
  logic held;
  logic req_held;
  int   stall_mode, taken, err_count, tests_run, tests_failed, errs0, items0, quiet;
  bit   bus_random;

  // Instruction memory contents, a pure function of the word address.
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[24:0], addr[31:25]} ^ 32'h1357_9bdf;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  fetch_top #(.FIFO_DEPTH(FIFO_DEPTH), .INITIAL_PC(INITIAL_PC)) UUT (
    .i_clk(clk), .i_rst_n(rst_n),
    .i_cfg_we(cfg_we), .i_cfg_addr(cfg_addr), .i_cfg_wdata(cfg_wdata), .o_cfg_rdata(cfg_rdata),
    .o_bus_req_valid(bus_req_valid), .o_bus_addr(bus_addr), .i_bus_req_ready(bus_req_ready),
    .i_bus_rsp_valid(bus_rsp_valid), .i_bus_rsp_data(bus_rsp_data),
    .o_valid(out_valid), .o_pc(out_pc), .o_inst(out_inst), .i_stall(stall)
  );

  inst_bus_model u_bus (
    .i_clk(clk), .i_rst_n(rst_n), .i_req_valid(bus_req_valid), .i_req_addr(bus_addr),
    .i_ready(bus_ready), .i_latency(bus_lat), .o_req_ready(bus_req_ready),
    .o_rsp_valid(bus_rsp_valid), .o_rsp_addr(bus_rsp_addr)
  );

  assign bus_rsp_data = mem_word(bus_rsp_addr);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Consumer stall and bus choices, 1 ns after each rising edge.
  always @(posedge clk) begin
    #1;
    rng       = lcg_next(rng);
    stall     = (stall_mode == STALL_HOLD) || (stall_mode == STALL_RANDOM && rng[31:29] < 3'd3);
    bus_ready = bus_random ? (rng[27:25] > 3'd1) : 1'b1;
    bus_lat   = bus_random ? ({1'b0, rng[23:21]} + 4'd1) : 4'd1;
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // ####################################################################
  // Comparison of the consumer stream
  // ####################################################################

  always @(negedge clk) begin
    if (rst_n) begin
      if (req_held) begin                             // Request must wait for acceptance.
        check_word("o_bus_req_valid while held", {31'd0, bus_req_valid}, 32'd1);
        check_word("o_bus_addr while held", bus_addr, req_held_addr);
      end
      req_held      = bus_req_valid && !bus_req_ready;
      req_held_addr = bus_addr;
      if (out_valid && held) begin                    // Head must not move while stalled.
        check_word("o_pc while stalled", out_pc, held_pc);
        check_word("o_inst while stalled", out_inst, held_inst);
      end
      if (out_valid && !stall) begin
        check_word("o_pc", out_pc, exp_pc);
        check_word("o_inst", out_inst, mem_word(exp_pc));
        exp_pc = exp_pc + 32'd4;
        taken++;
      end
      held      = out_valid && stall;
      held_pc   = out_pc;
      held_inst = out_inst;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  task automatic write_reg(input fetch_pkg::reg_addr_t addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);                                   // Write lands on this edge.
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic read_reg(input fetch_pkg::reg_addr_t addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic set_modes(input int stall_sel, input bit bus_sel);
    @(negedge clk);
    stall_mode = stall_sel;
    bus_random = bus_sel;
  endtask

  task automatic wait_items(input int n);
    int target;
    target = taken + n;
    while (taken < target) @(posedge clk);
  endtask

  task automatic start_test();
    errs0  = err_count;
    items0 = taken;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count != errs0) tests_failed++;
    $display("test %0d %-22s %s  items %0d  errors %0d", tests_run, name,
             (err_count == errs0) ? "ok" : "FAILED", taken - items0, err_count - errs0);
  endtask

  // ####################################################################
  // Test sequence
  // ####################################################################

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = fetch_pkg::REG_CTRL;
    cfg_wdata    = '0;
    stall        = 1'b0;
    bus_ready    = 1'b0;
    bus_lat      = 4'd1;
    stall_mode   = STALL_NONE;
    bus_random   = 0;
    rng          = 32'hd4f2_9914;
    exp_pc       = INITIAL_PC;
    held         = 1'b0;
    req_held     = 1'b0;
    taken        = 0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    start_test();
    write_reg(fetch_pkg::REG_CTRL, 32'd1);
    wait_items(N_SEQ);
    finish_test("sequential fetch");

    start_test();
    set_modes(STALL_RANDOM, 1);
    wait_items(N_RAND);
    finish_test("back-pressure");

    start_test();
    wait_items(N_PRE);
    d = '0;
    while (d[30:0] == 0) read_reg(fetch_pkg::REG_STATUS, d);   // Wait for work in flight.
    write_reg(fetch_pkg::REG_REDIRECT, PC_TRAFFIC);
    exp_pc = PC_TRAFFIC;
    wait_items(N_POST);
    finish_test("redirect in traffic");

    start_test();
    set_modes(STALL_HOLD, 1);
    quiet = 0;
    while (quiet < 3) begin                           // FIFO full and bus drained.
      read_reg(fetch_pkg::REG_STATUS, d);
      quiet = (d[30:0] == 0 && !bus_req_valid && out_valid) ? quiet + 1 : 0;
    end
    write_reg(fetch_pkg::REG_REDIRECT, PC_IDLE);
    exp_pc = PC_IDLE;
    read_reg(fetch_pkg::REG_STATUS, d);
    check_word("status flush busy", {31'd0, d[31]}, 32'd0);
    set_modes(STALL_RANDOM, 1);
    wait_items(N_IDLE);
    finish_test("redirect when idle");

    start_test();
    write_reg(fetch_pkg::REG_CTRL, 32'd0);
    exp_pc = INITIAL_PC;
    repeat (6) @(posedge clk);
    write_reg(fetch_pkg::REG_CTRL, 32'd1);
    wait_items(N_RESTART);
    finish_test("disable and re-enable");

    start_test();
    read_reg(fetch_pkg::REG_CTRL, d);
    check_word("ctrl", d, 32'd1);
    write_reg(fetch_pkg::REG_CTRL, 32'd0);
    exp_pc = INITIAL_PC;
    write_reg(fetch_pkg::REG_REDIRECT, PC_PARKED);
    read_reg(fetch_pkg::REG_REDIRECT, d);
    check_word("redirect pc", d, PC_PARKED);
    @(negedge clk);
    while (bus_req_valid) @(negedge clk);
    repeat (16) @(posedge clk);                       // Longer than any response delay.
    read_reg(fetch_pkg::REG_STATUS, d);
    check_word("status", d, 32'd0);
    read_reg(fetch_pkg::REG_CTRL, d);
    check_word("ctrl", d, 32'd0);
    finish_test("register read-back");

    $display("summary: %0d tests, %0d failed, %0d items checked, %0d errors",
             tests_run, tests_failed, taken, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: fetch.f
hw/fetch_pkg.sv
hw/inst_fifo.sv
hw/fetch_stage.sv
hw/fetch_ctrl_regs.sv
hw/fetch_top.sv
verif/inst_bus_model.sv
verif/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
